// File: sim.f
common/cpu_pkg.sv
hdl/sram.sv
hdl/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu.sv
bench/cpu_checker.sv
bench/tb_cpu.sv

// File: Makefile
# Verilator build and run for the pipelined cpu

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_cpu.sv
// cpu testbench: random programs, memory loading, run phases and the final verdict
module tb_cpu
   import cpu_pkg::*;
();

   localparam int rounds       = 3;
   localparam int reset_cycles = 8;
   localparam int run_cycles   = 300;
   localparam int rand_words   = 48;
   localparam int tail_words   = 15;
   localparam int prog_words   = rand_words + tail_words + 1;
   localparam int clear_words  = 64;
   localparam int tail_base    = 64;
   // every phase of one round plus a little slack for idle cycles
   localparam int round_cycles = reset_cycles + clear_words + 2 * tail_words + 2 * prog_words
                                 + run_cycles + clear_words + 2 * tail_words + 20;
   localparam int max_cycles   = rounds * round_cycles;

   logic                   clk;
   logic                   arst_n;
   logic                   enable;
   logic [imem_addr_w-1:0] imem_addr;
   logic                   imem_wen;
   logic                   imem_ren;
   logic [data_w-1:0]      imem_wdata;
   logic [data_w-1:0]      imem_rdata;
   logic [dmem_addr_w-1:0] dmem_addr;
   logic                   dmem_wen;
   logic                   dmem_ren;
   logic [data_w-1:0]      dmem_wdata;
   logic [data_w-1:0]      dmem_rdata;
   logic [31:0]            lcg_state;
   int                     cycle_count = 0;

   cpu DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .imem_addr (imem_addr),
      .imem_wen  (imem_wen),
      .imem_ren  (imem_ren),
      .imem_wdata(imem_wdata),
      .imem_rdata(imem_rdata),
      .dmem_addr (dmem_addr),
      .dmem_wen  (dmem_wen),
      .dmem_ren  (dmem_ren),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata)
   );

   cpu_checker chk (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .imem_addr (imem_addr),
      .imem_wen  (imem_wen),
      .imem_ren  (imem_ren),
      .imem_wdata(imem_wdata),
      .imem_rdata(imem_rdata),
      .dmem_addr (dmem_addr),
      .dmem_wen  (dmem_wen),
      .dmem_ren  (dmem_ren),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // upper half of the state since the low bits repeat quickly
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {16'h0000, lcg_state[31:16]};
   endfunction

   function automatic int rand_below(input int n);
      return int'(next_rand() % 32'(n));
   endfunction

   function automatic logic [data_w-1:0] rand_word();
      logic [15:0] hi;
      hi = 16'(next_rand());
      return {hi, 16'(next_rand())};
   endfunction

   function automatic logic [data_w-1:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] rd, input logic [4:0] shamt,
                                                input logic [5:0] funct);
      return {op_r_type, rs, rt, rd, shamt, funct};
   endfunction

   function automatic logic [data_w-1:0] i_word(input opcode_e op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // destinations r1..r7, memory offsets from r0, branches and jumps only forward
   function automatic logic [data_w-1:0] random_instr(input int idx);
      int         kind;
      int         target;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
      kind   = rand_below(16);
      rs     = 5'(rand_below(8));
      rt     = 5'(rand_below(8));
      rd     = 5'(1 + rand_below(7));
      shamt  = '0;
      target = idx + 1 + rand_below(4);
      if (target > rand_words) begin
         target = rand_words;
      end
      case (rand_below(6))
         0:       funct = funct_add;
         1:       funct = funct_sub;
         2:       funct = funct_and;
         3:       funct = funct_or;
         4:       funct = funct_slt;
         default: funct = funct_sll;
      endcase
      if (funct == funct_sll) begin
         rs    = '0;
         shamt = 5'(rand_below(32));
      end
      if (kind < 6) begin
         return r_word(rs, rt, rd, shamt, funct);
      end else if (kind < 9) begin
         return i_word(op_addi, rs, rd, 16'(next_rand()));
      end else if (kind < 11) begin
         return i_word(op_lw, 5'd0, rd, 16'(4 * rand_below(64)));
      end else if (kind < 13) begin
         return i_word(op_sw, 5'd0, rt, 16'(4 * rand_below(64)));
      end else if (kind < 15) begin
         return i_word(op_beq, rs, rt, 16'(target - idx - 1));
      end else begin
         return {op_j, 26'(target)};
      end
   endfunction

   // one port operation per cycle and all enables drop unless set again
   task automatic next_cycle();
      @(posedge clk);
      #1;
      imem_wen = 1'b0;
      imem_ren = 1'b0;
      dmem_wen = 1'b0;
      dmem_ren = 1'b0;
   endtask

   task automatic imem_write(input int idx, input logic [data_w-1:0] word);
      next_cycle();
      imem_addr  = imem_addr_w'(idx);
      imem_wdata = word;
      imem_wen   = 1'b1;
   endtask

   task automatic imem_read(input int idx);
      next_cycle();
      imem_addr = imem_addr_w'(idx);
      imem_ren  = 1'b1;
   endtask

   task automatic dmem_write(input int idx, input logic [data_w-1:0] word);
      next_cycle();
      dmem_addr  = dmem_addr_w'(idx);
      dmem_wdata = word;
      dmem_wen   = 1'b1;
   endtask

   task automatic dmem_read(input int idx);
      next_cycle();
      dmem_addr = dmem_addr_w'(idx);
      dmem_ren  = 1'b1;
   endtask

   task automatic reset_core();
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      arst_n = 1'b1;
   endtask

   task automatic fill_dmem();
      for (int w = 0; w < clear_words; w++) begin
         dmem_write(w, '0);
      end
      // tail region gets random words so that every tail store shows
      for (int w = tail_base; w < tail_base + tail_words; w++) begin
         dmem_write(w, rand_word());
      end
      for (int w = tail_base; w < tail_base + tail_words; w++) begin
         dmem_read(w);
      end
      next_cycle();
   endtask

   task automatic load_program();
      for (int i = 0; i < rand_words; i++) begin
         imem_write(i, random_instr(i));
      end
      for (int k = 1; k <= tail_words; k++) begin
         imem_write(rand_words + k - 1,
                    i_word(op_sw, 5'd0, 5'(k), 16'(4 * (tail_base + k - 1))));
      end
      imem_write(prog_words - 1, {op_j, 26'(prog_words - 1)});
      for (int i = 0; i < prog_words; i++) begin
         imem_read(i);
      end
      next_cycle();
   endtask

   task automatic run_core();
      next_cycle();
      enable = 1'b1;
      repeat (run_cycles) @(posedge clk);
      #1;
      enable = 1'b0;
   endtask

   // tail region twice while the frozen core must leave it unchanged
   task automatic read_back();
      for (int w = 0; w < tail_base + tail_words; w++) begin
         dmem_read(w);
      end
      for (int w = tail_base; w < tail_base + tail_words; w++) begin
         dmem_read(w);
      end
      next_cycle();
      next_cycle();
   endtask

   initial begin
      lcg_state  = 32'd70;
      arst_n     = 1'b0;
      enable     = 1'b0;
      imem_addr  = '0;
      imem_wen   = 1'b0;
      imem_ren   = 1'b0;
      imem_wdata = '0;
      dmem_addr  = '0;
      dmem_wen   = 1'b0;
      dmem_ren   = 1'b0;
      dmem_wdata = '0;
      for (int r = 0; r < rounds; r++) begin
         reset_core();
         fill_dmem();
         load_program();
         run_core();
         read_back();
      end
      repeat (2) @(posedge clk);
      $display("compares: %0d, data errors: %0d, model errors: %0d",
               chk.check_count, chk.data_errors, chk.model_errors);
      if (chk.data_errors == 0 && chk.model_errors == 0 && chk.check_count > 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > max_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("compares: %0d, data errors: %0d, model errors: %0d",
                  chk.check_count, chk.data_errors, chk.model_errors);
         $display("Test failed");
         $finish;
      end
   end

endmodule

// File: bench/cpu_checker.sv
// cpu checker: mirrors external memory writes, runs an instruction-set model, checks reads
module cpu_checker
   import cpu_pkg::*;
(
   input logic                   clk,
   input logic                   arst_n,
   input logic                   enable,
   input logic [imem_addr_w-1:0] imem_addr,
   input logic                   imem_wen,
   input logic                   imem_ren,
   input logic [data_w-1:0]      imem_wdata,
   input logic [data_w-1:0]      imem_rdata,
   input logic [dmem_addr_w-1:0] dmem_addr,
   input logic                   dmem_wen,
   input logic                   dmem_ren,
   input logic [data_w-1:0]      dmem_wdata,
   input logic [data_w-1:0]      dmem_rdata
);

   localparam int max_steps = 2000;

   logic [data_w-1:0]      imem_model [2**imem_addr_w];
   logic [data_w-1:0]      dmem_model [2**dmem_addr_w];
   logic [data_w-1:0]      regs [2**reg_addr_w];
   logic                   enable_q = 1'b0;
   logic                   imem_pending = 1'b0;
   logic                   dmem_pending = 1'b0;
   logic [imem_addr_w-1:0] imem_addr_q;
   logic [dmem_addr_w-1:0] dmem_addr_q;
   int                     check_count = 0;
   int                     data_errors = 0;
   int                     model_errors = 0;

   // sequential execution from address zero up to the final self-jump
   task automatic run_model();
      logic [31:0] pc;
      logic [31:0] pc4;
      logic [31:0] next_pc;
      logic [31:0] instr;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] simm;
      logic [31:0] addr;
      logic [31:0] result;
      logic [4:0]  dest;
      pc = '0;
      for (int steps = 0; steps < max_steps; steps++) begin
         instr   = imem_model[pc[imem_addr_w+1:2]];
         a       = regs[instr[25:21]];
         b       = regs[instr[20:16]];
         simm    = {{16{instr[15]}}, instr[15:0]};
         addr    = a + simm;
         pc4     = pc + 32'd4;
         next_pc = pc4;
         dest    = '0;
         result  = '0;
         case (instr[31:26])
            op_r_type: begin
               dest = instr[15:11];
               case (instr[5:0])
                  funct_add: result = a + b;
                  funct_sub: result = a - b;
                  funct_and: result = a & b;
                  funct_or:  result = a | b;
                  funct_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  funct_sll: result = b << instr[10:6];
                  default:   dest = '0;
               endcase
            end
            op_addi: begin
               dest   = instr[20:16];
               result = addr;
            end
            op_lw: begin
               dest   = instr[20:16];
               result = dmem_model[addr[dmem_addr_w+1:2]];
            end
            op_sw: dmem_model[addr[dmem_addr_w+1:2]] = b;
            op_beq: begin
               if (a == b) begin
                  next_pc = pc4 + {simm[29:0], 2'b00};
               end
            end
            op_j:    next_pc = {pc4[31:28], instr[25:0], 2'b00};
            default: dest = '0;
         endcase
         if (dest != '0) begin
            regs[dest] = result;
         end
         if (next_pc == pc) begin
            return;
         end
         pc = next_pc;
      end
      model_errors++;
      $display("model error at %0t: the program never reached its final self-jump", $time);
   endtask

   task automatic compare_word(input string mem_name, input int addr,
                               input logic [data_w-1:0] got, input logic [data_w-1:0] exp);
      check_count++;
      if (got !== exp) begin
         data_errors++;
         $display("FAILED at %0t: %s word %0d read 0x%08h, expected 0x%08h",
                  $time, mem_name, addr, got, exp);
      end
   endtask

   always @(posedge clk) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**reg_addr_w; i++) begin
            regs[i] = '0;
         end
      end
      if (imem_wen) begin
         imem_model[imem_addr] = imem_wdata;
      end
      if (dmem_wen) begin
         dmem_model[dmem_addr] = dmem_wdata;
      end
      // the whole program runs in zero time when the core starts
      if (enable && !enable_q) begin
         run_model();
      end
      enable_q     = enable;
      imem_pending = imem_ren;
      imem_addr_q  = imem_addr;
      dmem_pending = dmem_ren;
      dmem_addr_q  = dmem_addr;
   end

   // read data settles on the edge after the enable and is sampled mid cycle
   always @(negedge clk) begin
      if (imem_pending) begin
         compare_word("imem", int'(imem_addr_q), imem_rdata, imem_model[imem_addr_q]);
      end
      if (dmem_pending) begin
         compare_word("dmem", int'(dmem_addr_q), dmem_rdata, dmem_model[dmem_addr_q]);
      end
   end

endmodule

// File: hdl/cpu.sv
// cpu: five-stage pipelined core with external ports on both memories
module cpu
   import cpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   enable,
   input  logic [imem_addr_w-1:0] imem_addr,
   input  logic                   imem_wen,
   input  logic                   imem_ren,
   input  logic [data_w-1:0]      imem_wdata,
   output logic [data_w-1:0]      imem_rdata,
   input  logic [dmem_addr_w-1:0] dmem_addr,
   input  logic                   dmem_wen,
   input  logic                   dmem_ren,
   input  logic [data_w-1:0]      dmem_wdata,
   output logic [data_w-1:0]      dmem_rdata
);

   logic [data_w-1:0]     if_pc;
   logic [data_w-1:0]     if_instr;
   logic                  if_valid;
   ctrl_t                 id_ctrl;
   logic [data_w-1:0]     id_rs_data;
   logic [data_w-1:0]     id_rt_data;
   logic [data_w-1:0]     id_imm;
   logic [reg_addr_w-1:0] id_rs;
   logic [reg_addr_w-1:0] id_rt;
   logic [reg_addr_w-1:0] id_waddr;
   logic [reg_addr_w-1:0] id_shamt;
   logic [data_w-1:0]     id_pc4;
   logic [data_w-1:0]     id_jtarget;
   ctrl_t                 ex_ctrl;
   logic [data_w-1:0]     ex_alu;
   logic [data_w-1:0]     ex_store_data;
   logic [reg_addr_w-1:0] ex_waddr;
   logic                  wb_we;
   logic [reg_addr_w-1:0] wb_waddr;
   logic [data_w-1:0]     wb_wdata;
   logic                  stall;
   logic                  redirect;
   logic [data_w-1:0]     redirect_pc;
   logic                  flush;

   fetch_stage fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .stall      (stall),
      .redirect   (redirect),
      .redirect_pc(redirect_pc),
      .imem_addr  (imem_addr),
      .imem_wen   (imem_wen),
      .imem_ren   (imem_ren),
      .imem_wdata (imem_wdata),
      .imem_rdata (imem_rdata),
      .if_pc      (if_pc),
      .if_instr   (if_instr),
      .if_valid   (if_valid)
   );

   decode_stage decode (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .flush     (flush),
      .if_pc     (if_pc),
      .if_instr  (if_instr),
      .if_valid  (if_valid),
      .wb_we     (wb_we),
      .wb_waddr  (wb_waddr),
      .wb_wdata  (wb_wdata),
      .id_ctrl   (id_ctrl),
      .id_rs_data(id_rs_data),
      .id_rt_data(id_rt_data),
      .id_imm    (id_imm),
      .id_rs     (id_rs),
      .id_rt     (id_rt),
      .id_waddr  (id_waddr),
      .id_shamt  (id_shamt),
      .id_pc4    (id_pc4),
      .id_jtarget(id_jtarget),
      .stall     (stall)
   );

   execute_stage execute (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .id_ctrl      (id_ctrl),
      .id_rs_data   (id_rs_data),
      .id_rt_data   (id_rt_data),
      .id_imm       (id_imm),
      .id_rs        (id_rs),
      .id_rt        (id_rt),
      .id_waddr     (id_waddr),
      .id_shamt     (id_shamt),
      .id_pc4       (id_pc4),
      .id_jtarget   (id_jtarget),
      .wb_we        (wb_we),
      .wb_waddr     (wb_waddr),
      .wb_wdata     (wb_wdata),
      .ex_ctrl      (ex_ctrl),
      .ex_alu       (ex_alu),
      .ex_store_data(ex_store_data),
      .ex_waddr     (ex_waddr),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .flush        (flush)
   );

   mem_wb_stage mem_wb (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .ex_ctrl      (ex_ctrl),
      .ex_alu       (ex_alu),
      .ex_store_data(ex_store_data),
      .ex_waddr     (ex_waddr),
      .dmem_addr    (dmem_addr),
      .dmem_wen     (dmem_wen),
      .dmem_ren     (dmem_ren),
      .dmem_wdata   (dmem_wdata),
      .dmem_rdata   (dmem_rdata),
      .wb_we        (wb_we),
      .wb_waddr     (wb_waddr),
      .wb_wdata     (wb_wdata)
   );

endmodule

// File: hdl/mem_wb_stage.sv
// memory and writeback stage: data memory, memory/writeback register, writeback select
module mem_wb_stage
   import cpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   enable,
   input  ctrl_t                  ex_ctrl,
   input  logic [data_w-1:0]      ex_alu,
   input  logic [data_w-1:0]      ex_store_data,
   input  logic [reg_addr_w-1:0]  ex_waddr,
   input  logic [dmem_addr_w-1:0] dmem_addr,
   input  logic                   dmem_wen,
   input  logic                   dmem_ren,
   input  logic [data_w-1:0]      dmem_wdata,
   output logic [data_w-1:0]      dmem_rdata,
   output logic                   wb_we,
   output logic [reg_addr_w-1:0]  wb_waddr,
   output logic [data_w-1:0]      wb_wdata
);

   logic              mem_to_reg;
   logic [data_w-1:0] load_data;
   logic [data_w-1:0] alu_q;

   sram #(
      .addr_w(dmem_addr_w),
      .data_w(data_w)
   ) data_mem (
      .clk      (clk),
      .addr     (ex_alu[dmem_addr_w+1:2]),
      .wen      (enable && ex_ctrl.mem_write),
      .ren      (enable && ex_ctrl.mem_read),
      .wdata    (ex_store_data),
      .rdata    (load_data),
      .addr_ext (dmem_addr),
      .wen_ext  (dmem_wen),
      .ren_ext  (dmem_ren),
      .wdata_ext(dmem_wdata),
      .rdata_ext(dmem_rdata)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_we      <= 1'b0;
         mem_to_reg <= 1'b0;
      end else if (enable) begin
         wb_we      <= ex_ctrl.reg_write;
         mem_to_reg <= ex_ctrl.mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         wb_waddr <= ex_waddr;
         alu_q    <= ex_alu;
      end
   end

   // load data lines up with the registered read
   assign wb_wdata = mem_to_reg ? load_data : alu_q;

endmodule

// File: execute/execute_stage.sv
// execute stage: operand forwarding, alu, branch and jump resolution, execute/memory register
module execute_stage
   import cpu_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enable,
   input  ctrl_t                 id_ctrl,
   input  logic [data_w-1:0]     id_rs_data,
   input  logic [data_w-1:0]     id_rt_data,
   input  logic [data_w-1:0]     id_imm,
   input  logic [reg_addr_w-1:0] id_rs,
   input  logic [reg_addr_w-1:0] id_rt,
   input  logic [reg_addr_w-1:0] id_waddr,
   input  logic [reg_addr_w-1:0] id_shamt,
   input  logic [data_w-1:0]     id_pc4,
   input  logic [data_w-1:0]     id_jtarget,
   input  logic                  wb_we,
   input  logic [reg_addr_w-1:0] wb_waddr,
   input  logic [data_w-1:0]     wb_wdata,
   output ctrl_t                 ex_ctrl,
   output logic [data_w-1:0]     ex_alu,
   output logic [data_w-1:0]     ex_store_data,
   output logic [reg_addr_w-1:0] ex_waddr,
   output logic                  redirect,
   output logic [data_w-1:0]     redirect_pc,
   output logic                  flush
);

   logic              mem_fwd_ok;
   logic              wb_fwd_ok;
   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b_reg;
   logic [data_w-1:0] op_b;
   logic [data_w-1:0] result;

   // a load in the memory stage has no value yet and the interlock covers it
   assign mem_fwd_ok = ex_ctrl.reg_write && !ex_ctrl.mem_read && ex_waddr != '0;
   assign wb_fwd_ok  = wb_we && wb_waddr != '0;

   always_comb begin
      op_a = id_rs_data;
      if (mem_fwd_ok && ex_waddr == id_rs) begin
         op_a = ex_alu;
      end else if (wb_fwd_ok && wb_waddr == id_rs) begin
         op_a = wb_wdata;
      end
      op_b_reg = id_rt_data;
      if (mem_fwd_ok && ex_waddr == id_rt) begin
         op_b_reg = ex_alu;
      end else if (wb_fwd_ok && wb_waddr == id_rt) begin
         op_b_reg = wb_wdata;
      end
   end

   assign op_b = id_ctrl.alu_src_imm ? id_imm : op_b_reg;

   always_comb begin
      case (id_ctrl.alu_op)
         alu_and: result = op_a & op_b;
         alu_or:  result = op_a | op_b;
         alu_sub: result = op_a - op_b;
         alu_slt: result = {{(data_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         alu_sll: result = op_b << id_shamt;
         default: result = op_a + op_b;
      endcase
   end

   assign redirect    = id_ctrl.jump || (id_ctrl.branch && op_a == op_b_reg);
   assign redirect_pc = id_ctrl.jump ? id_jtarget : id_pc4 + {id_imm[data_w-3:0], 2'b00};
   assign flush       = redirect;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_ctrl <= '0;
      end else if (enable) begin
         ex_ctrl <= id_ctrl;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_alu        <= result;
         ex_store_data <= op_b_reg;
         ex_waddr      <= id_waddr;
      end
   end

   // the slot behind a taken redirect arrives as a bubble
   a_redirect_bubble: assert property (
      @(posedge clk) disable iff (!arst_n) (redirect && enable) |=> !redirect)
      else $error("execute: redirect from a squashed slot");

endmodule

// File: decode/decode_stage.sv
// decode stage: control decode, register read, load-use interlock, decode/execute register
module decode_stage
   import cpu_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enable,
   input  logic                  flush,
   input  logic [data_w-1:0]     if_pc,
   input  logic [data_w-1:0]     if_instr,
   input  logic                  if_valid,
   input  logic                  wb_we,
   input  logic [reg_addr_w-1:0] wb_waddr,
   input  logic [data_w-1:0]     wb_wdata,
   output ctrl_t                 id_ctrl,
   output logic [data_w-1:0]     id_rs_data,
   output logic [data_w-1:0]     id_rt_data,
   output logic [data_w-1:0]     id_imm,
   output logic [reg_addr_w-1:0] id_rs,
   output logic [reg_addr_w-1:0] id_rt,
   output logic [reg_addr_w-1:0] id_waddr,
   output logic [reg_addr_w-1:0] id_shamt,
   output logic [data_w-1:0]     id_pc4,
   output logic [data_w-1:0]     id_jtarget,
   output logic                  stall
);

   logic [op_w-1:0]       opcode;
   logic [op_w-1:0]       funct;
   logic [reg_addr_w-1:0] rs;
   logic [reg_addr_w-1:0] rt;
   logic [reg_addr_w-1:0] rd;
   logic [imm_w-1:0]      imm;
   logic [data_w-1:0]     pc4;
   logic [data_w-1:0]     rs_data;
   logic [data_w-1:0]     rt_data;
   ctrl_t                 ctrl;

   assign opcode = if_instr[opcode_lsb +: op_w];
   assign funct  = if_instr[funct_lsb +: op_w];
   assign rs     = if_instr[rs_lsb +: reg_addr_w];
   assign rt     = if_instr[rt_lsb +: reg_addr_w];
   assign rd     = if_instr[rd_lsb +: reg_addr_w];
   assign imm    = if_instr[imm_lsb +: imm_w];
   assign pc4    = if_pc + data_w'(4);
   assign ctrl   = if_valid ? decode_ctrl(opcode, funct) : '0;

   // load in execute feeding this instruction
   assign stall = if_valid && id_ctrl.mem_read && id_waddr != '0 &&
                  (id_waddr == rs || id_waddr == rt);

   register_file regs (
      .clk    (clk),
      .arst_n (arst_n),
      .we     (wb_we && enable),
      .waddr  (wb_waddr),
      .wdata  (wb_wdata),
      .raddr_1(rs),
      .raddr_2(rt),
      .rdata_1(rs_data),
      .rdata_2(rt_data)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ctrl <= '0;
      end else if (enable) begin
         id_ctrl <= (stall || flush) ? '0 : ctrl;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         id_rs_data <= rs_data;
         id_rt_data <= rt_data;
         id_imm     <= {{(data_w-imm_w){imm[imm_w-1]}}, imm};
         id_rs      <= rs;
         id_rt      <= rt;
         id_waddr   <= ctrl.reg_dst_rd ? rd : rt;
         id_shamt   <= if_instr[shamt_lsb +: reg_addr_w];
         id_pc4     <= pc4;
         id_jtarget <= {pc4[data_w-1:jidx_w+2], if_instr[jidx_w-1:0], 2'b00};
      end
   end

   a_stall_flush: assert property (@(posedge clk) disable iff (!arst_n) !(stall && flush))
      else $error("decode: stall and flush high together");

endmodule

// File: decode/register_file.sv
// register file: 32 registers, two read ports with write-through bypass, r0 reads zero
module register_file
   import cpu_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  we,
   input  logic [reg_addr_w-1:0] waddr,
   input  logic [data_w-1:0]     wdata,
   input  logic [reg_addr_w-1:0] raddr_1,
   input  logic [reg_addr_w-1:0] raddr_2,
   output logic [data_w-1:0]     rdata_1,
   output logic [data_w-1:0]     rdata_2
);

   logic [data_w-1:0] regs [2**reg_addr_w];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**reg_addr_w; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // writeback in the same cycle is seen by decode
   always_comb begin
      rdata_1 = regs[raddr_1];
      rdata_2 = regs[raddr_2];
      if (we && waddr != '0 && waddr == raddr_1) begin
         rdata_1 = wdata;
      end
      if (we && waddr != '0 && waddr == raddr_2) begin
         rdata_2 = wdata;
      end
      if (raddr_1 == '0) begin
         rdata_1 = '0;
      end
      if (raddr_2 == '0) begin
         rdata_2 = '0;
      end
   end

endmodule

// File: hdl/fetch_stage.sv
// fetch stage: program counter, instruction memory and the fetch/decode register
module fetch_stage
   import cpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   enable,
   input  logic                   stall,
   input  logic                   redirect,
   input  logic [data_w-1:0]      redirect_pc,
   input  logic [imem_addr_w-1:0] imem_addr,
   input  logic                   imem_wen,
   input  logic                   imem_ren,
   input  logic [data_w-1:0]      imem_wdata,
   output logic [data_w-1:0]      imem_rdata,
   output logic [data_w-1:0]      if_pc,
   output logic [data_w-1:0]      if_instr,
   output logic                   if_valid
);

   logic [data_w-1:0] pc;

   // redirect wins over stall
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= '0;
         if_valid <= 1'b0;
      end else if (enable) begin
         if (redirect) begin
            pc       <= redirect_pc;
            if_valid <= 1'b0;
         end else if (!stall) begin
            pc       <= pc + data_w'(4);
            if_valid <= 1'b1;
         end
      end
   end

   // pc travels alongside the registered instruction read
   always_ff @(posedge clk) begin
      if (enable && !stall) begin
         if_pc <= pc;
      end
   end

   sram #(
      .addr_w(imem_addr_w),
      .data_w(data_w)
   ) instr_mem (
      .clk      (clk),
      .addr     (pc[imem_addr_w+1:2]),
      .wen      (1'b0),
      .ren      (enable && !stall),
      .wdata    ('0),
      .rdata    (if_instr),
      .addr_ext (imem_addr),
      .wen_ext  (imem_wen),
      .ren_ext  (imem_ren),
      .wdata_ext(imem_wdata),
      .rdata_ext(imem_rdata)
   );

endmodule

// File: hdl/sram.sv
// sram: word memory with a core port and an external port, both reads registered
module sram #(
   parameter int addr_w = 9,
   parameter int data_w = 32
) (
   input  logic              clk,
   input  logic [addr_w-1:0] addr,
   input  logic              wen,
   input  logic              ren,
   input  logic [data_w-1:0] wdata,
   output logic [data_w-1:0] rdata,
   input  logic [addr_w-1:0] addr_ext,
   input  logic              wen_ext,
   input  logic              ren_ext,
   input  logic [data_w-1:0] wdata_ext,
   output logic [data_w-1:0] rdata_ext
);

   logic [data_w-1:0] mem [2**addr_w];

   // external write comes last so it wins on a clash
   always_ff @(posedge clk) begin
      if (wen) begin
         mem[addr] <= wdata;
      end
      if (wen_ext) begin
         mem[addr_ext] <= wdata_ext;
      end
   end

   always_ff @(posedge clk) begin
      if (ren) begin
         rdata <= mem[addr];
      end
      if (ren_ext) begin
         rdata_ext <= mem[addr_ext];
      end
   end

   a_no_write_clash: assert property (@(posedge clk) !(wen && wen_ext && addr == addr_ext))
      else $error("sram: core and external port write the same word");

endmodule

// File: common/cpu_pkg.sv
// cpu package: widths, instruction fields, opcode and alu encodings, control decode
package cpu_pkg;

   localparam int data_w      = 32;
   localparam int reg_addr_w  = 5;
   localparam int imem_addr_w = 9;
   localparam int dmem_addr_w = 10;

   // instruction field positions
   localparam int op_w        = 6;
   localparam int opcode_lsb  = 26;
   localparam int rs_lsb      = 21;
   localparam int rt_lsb      = 16;
   localparam int rd_lsb      = 11;
   localparam int shamt_lsb   = 6;
   localparam int funct_lsb   = 0;
   localparam int imm_lsb     = 0;
   localparam int imm_w       = 16;
   localparam int jidx_w      = 26;

   // r-type funct codes
   localparam logic [op_w-1:0] funct_sll = 6'h00;
   localparam logic [op_w-1:0] funct_add = 6'h20;
   localparam logic [op_w-1:0] funct_sub = 6'h22;
   localparam logic [op_w-1:0] funct_and = 6'h24;
   localparam logic [op_w-1:0] funct_or  = 6'h25;
   localparam logic [op_w-1:0] funct_slt = 6'h2a;

   typedef enum logic [op_w-1:0] {
      op_r_type = 6'h00,
      op_j      = 6'h02,
      op_beq    = 6'h04,
      op_addi   = 6'h08,
      op_lw     = 6'h23,
      op_sw     = 6'h2b
   } opcode_e;

   typedef enum logic [3:0] {
      alu_and = 4'd0,
      alu_or  = 4'd1,
      alu_add = 4'd2,
      alu_sll = 4'd3,
      alu_sub = 4'd6,
      alu_slt = 4'd7
   } alu_op_e;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      logic    alu_src_imm;
      logic    reg_dst_rd;
      logic    branch;
      logic    jump;
      alu_op_e alu_op;
   } ctrl_t;

   function automatic ctrl_t decode_ctrl(input logic [op_w-1:0] opcode,
                                         input logic [op_w-1:0] funct);
      ctrl_t c;
      c = '0;
      c.alu_op = alu_add;
      case (opcode)
         op_r_type: begin
            c.reg_write  = 1'b1;
            c.reg_dst_rd = 1'b1;
            case (funct)
               funct_add: c.alu_op = alu_add;
               funct_sub: c.alu_op = alu_sub;
               funct_and: c.alu_op = alu_and;
               funct_or:  c.alu_op = alu_or;
               funct_slt: c.alu_op = alu_slt;
               funct_sll: c.alu_op = alu_sll;
               // unsupported funct behaves as a nop
               default:   c.reg_write = 1'b0;
            endcase
         end
         op_addi: begin
            c.reg_write   = 1'b1;
            c.alu_src_imm = 1'b1;
         end
         op_lw: begin
            c.reg_write   = 1'b1;
            c.mem_read    = 1'b1;
            c.mem_to_reg  = 1'b1;
            c.alu_src_imm = 1'b1;
         end
         op_sw: begin
            c.mem_write   = 1'b1;
            c.alu_src_imm = 1'b1;
         end
         op_beq: begin
            c.branch = 1'b1;
            c.alu_op = alu_sub;
         end
         op_j:    c.jump = 1'b1;
         default: c = '0;
      endcase
      return c;
   endfunction

endpackage
